// ==== tone_pkg.sv ====
package tone_pkg;

    typedef logic [17:0] angle_t;           // phase in radians, 14 fractional bits
    typedef logic [17:0] step_t;            // phase increment per sample, below pi
    typedef logic signed [15:0] sample_t;   // signed sine sample, about +-32767

    localparam angle_t PI2 = 18'd25736;     // pi/2 in angle units

    // x start value, cordic gain compensation scaled by 65535
    localparam logic signed [17:0] AG_CONST = 18'sd39796;

    localparam angle_t CORDIC_ATAN [19] = '{
        18'd12868,                          // atan(2^-0)
        18'd7596,                           // atan(2^-1)
        18'd4014,
        18'd2037,
        18'd1023,
        18'd512,
        18'd256,
        18'd128,                            // from here on roughly halving
        18'd64,
        18'd32,
        18'd16,
        18'd8,
        18'd4,
        18'd2,
        18'd1,
        18'd1,                              // 0.5 rounded up
        18'd0,
        18'd0,
        18'd0                               // tail entries below one lsb
    };

    typedef enum logic [1:0] {
        CS_IDLE,                            // waiting for the first update
        CS_INIT,                            // load x, y and the angle accumulator
        CS_COMPUTE,                         // one rotation per cycle
        CS_DONE                             // result valid, ready high
    } cordic_state_t;

endpackage

// ==== phase_sequencer.sv ====
`timescale 1ns/1ps

module phase_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  tone_pkg::step_t   tone_step,
    input  logic              ready,
    input  tone_pkg::sample_t sine,
    input  logic              full,
    output logic              update,
    output tone_pkg::angle_t  angle,
    output logic              push,
    output tone_pkg::sample_t push_data
);

    localparam tone_pkg::angle_t FULL_TURN = tone_pkg::angle_t'(4 * tone_pkg::PI2);   // 2*pi

    typedef enum logic {
        SEQ_IDLE,                           // no conversion in flight
        SEQ_BUSY                            // engine working on angle
    } seq_state_t;

    seq_state_t       state;
    tone_pkg::angle_t phase;                // current sample phase
    logic [18:0]      phase_sum;            // one spare bit for the carry
    logic [18:0]      phase_wrap;

    // a new conversion only when the fifo can take its result
    assign update    = (state == SEQ_IDLE) && enable && !full;
    assign push      = (state == SEQ_BUSY) && ready;    // first ready cycle after update
    assign push_data = sine;
    assign angle     = phase;               // held until the result is pushed

    assign phase_sum  = {1'b0, phase} + {1'b0, tone_step};
    assign phase_wrap = (phase_sum >= {1'b0, FULL_TURN}) ? phase_sum - {1'b0, FULL_TURN}
                                                         : phase_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            phase <= '0;                    // first sample is sin(0)
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (update) begin
                        state <= SEQ_BUSY;
                    end
                end
                SEQ_BUSY: begin
                    if (ready) begin        // result taken this cycle
                        state <= SEQ_IDLE;
                        phase <= phase_wrap[17:0];  // tone_step sampled here
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== cordic_sine.sv ====
`timescale 1ns/1ps

module cordic_sine (
    input  logic              clk,
    input  logic              reset,
    input  logic              update,
    input  tone_pkg::angle_t  angle,
    output logic              ready,
    output tone_pkg::sample_t sine
);

    localparam tone_pkg::angle_t HALF_TURN  = tone_pkg::angle_t'(2 * tone_pkg::PI2);  // pi
    localparam tone_pkg::angle_t THREE_QTR  = tone_pkg::angle_t'(3 * tone_pkg::PI2);  // 3pi/2
    localparam tone_pkg::angle_t FULL_TURN  = tone_pkg::angle_t'(4 * tone_pkg::PI2);  // 2pi
    localparam logic [4:0]       LAST_STEP  = 5'd16;    // 17 rotations, steps 0..16

    tone_pkg::cordic_state_t state;
    tone_pkg::cordic_state_t state_next;
    logic [4:0]              ctr;           // rotation index

    tone_pkg::angle_t   mid_angle;          // input folded below 2pi
    tone_pkg::angle_t   target_angle;       // first quadrant equivalent
    logic [1:0]         quadrant;

    logic signed [17:0] x;
    logic signed [17:0] y;
    logic signed [17:0] cur_angle;          // accumulated rotation, may go negative
    logic signed [17:0] x_shift;
    logic signed [17:0] y_shift;
    logic signed [17:0] atan_step;
    logic signed [17:0] y_out;
    logic               rotate_up;

    // angle is read straight from the port, the sequencer keeps it stable
    always_comb begin
        mid_angle = (angle > FULL_TURN) ? angle - FULL_TURN : angle;
        if (mid_angle > THREE_QTR) begin
            quadrant     = 2'd3;
            target_angle = FULL_TURN - mid_angle;   // mirror about 2pi
        end else if (mid_angle > HALF_TURN) begin
            quadrant     = 2'd2;
            target_angle = mid_angle - HALF_TURN;   // shift back by pi
        end else if (mid_angle > tone_pkg::PI2) begin
            quadrant     = 2'd1;
            target_angle = HALF_TURN - mid_angle;   // mirror about pi/2
        end else begin
            quadrant     = 2'd0;
            target_angle = mid_angle;
        end
    end

    assign x_shift   = x >>> ctr;           // arithmetic shifts keep the sign
    assign y_shift   = y >>> ctr;
    assign atan_step = $signed(tone_pkg::CORDIC_ATAN[ctr]);
    assign rotate_up = $signed(target_angle) > cur_angle;   // steer toward the target

    always_comb begin
        state_next = state;
        case (state)
            tone_pkg::CS_IDLE:    if (update) state_next = tone_pkg::CS_INIT;
            tone_pkg::CS_INIT:    state_next = tone_pkg::CS_COMPUTE;
            tone_pkg::CS_COMPUTE: if (ctr == LAST_STEP) state_next = tone_pkg::CS_DONE;
            tone_pkg::CS_DONE:    if (update) state_next = tone_pkg::CS_INIT;
            default:              state_next = tone_pkg::CS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tone_pkg::CS_IDLE;
            ctr   <= '0;
        end else begin
            state <= state_next;
            if (state == tone_pkg::CS_INIT) begin
                ctr <= '0;
            end else if (state == tone_pkg::CS_COMPUTE) begin
                ctr <= ctr + 5'd1;
            end
        end
    end

    // rotation datapath, only meaningful from init onward
    always_ff @(posedge clk) begin
        if (state == tone_pkg::CS_INIT) begin
            x         <= tone_pkg::AG_CONST;   // gain compensated cos(0)
            y         <= '0;
            cur_angle <= '0;
        end else if (state == tone_pkg::CS_COMPUTE) begin
            if (rotate_up) begin
                x         <= x - y_shift;
                y         <= y + x_shift;
                cur_angle <= cur_angle + atan_step;
            end else begin
                x         <= x + y_shift;
                y         <= y - x_shift;
                cur_angle <= cur_angle - atan_step;
            end
        end
    end

    // y is about 65535 at full scale, halve it and restore the sign
    assign y_out = (quadrant < 2'd2) ? (y >>> 1) : ((-y) >>> 1);

    assign ready = (state == tone_pkg::CS_DONE);
    assign sine  = ready ? y_out[15:0] : '0;

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 4            // power of two, at least 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  tone_pkg::sample_t push_data,
    input  logic              pop,
    output tone_pkg::sample_t pop_data,
    output logic              full,
    output logic              empty
);

    localparam int AW = $clog2(FIFO_DEPTH); // address width

    tone_pkg::sample_t mem [FIFO_DEPTH];    // storage, no reset needed
    logic [AW:0]       wr_ptr;              // msb is the wrap flag
    logic [AW:0]       rd_ptr;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = push && !full;           // drop writes that would overflow
    assign rd_en = pop && !empty;

    // same address, wrap flags differ -> one lap ahead
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign pop_data = mem[rd_ptr[AW-1:0]];  // show-ahead head entry

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

// ==== sample_serializer.sv ====
`timescale 1ns/1ps

module sample_serializer (
    input  logic              clk,
    input  logic              reset,
    input  tone_pkg::sample_t pop_data,
    input  logic              empty,
    input  logic              dac_hold,
    output logic              pop,
    output logic              sdata,
    output logic              sframe
);

    localparam logic [3:0] LAST_BIT = 4'd15;

    typedef enum logic {
        SER_IDLE,                           // between samples
        SER_SHIFT                           // 16 bit cycles
    } ser_state_t;

    ser_state_t        state;
    tone_pkg::sample_t shreg;               // msb goes out first
    logic [3:0]        bit_cnt;

    // hold only blocks the start of a sample, never a running one
    assign pop    = (state == SER_IDLE) && !empty && !dac_hold;
    assign sdata  = (state == SER_SHIFT) && shreg[15];
    assign sframe = (state == SER_SHIFT) && (bit_cnt == 4'd0);  // first bit only

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SER_IDLE;
            bit_cnt <= '0;
        end else if (state == SER_IDLE) begin
            if (pop) begin
                state   <= SER_SHIFT;
                bit_cnt <= '0;
            end
        end else begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == LAST_BIT) begin
                state <= SER_IDLE;          // next pop the cycle after bit 16
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= pop_data;              // load the fifo head
        end else if (state == SER_SHIFT) begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

endmodule

// ==== tone_gen_top.sv ====
`timescale 1ns/1ps

module tone_gen_top #(
    parameter int FIFO_DEPTH = 4            // power of two
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  tone_pkg::step_t tone_step,
    input  logic            dac_hold,
    output logic            sdata,
    output logic            sframe
);

    logic              update;              // sequencer -> engine strobe
    logic              ready;               // engine result valid
    logic              push;
    logic              pop;
    logic              full;
    logic              empty;
    tone_pkg::angle_t  angle;
    tone_pkg::sample_t sine;
    tone_pkg::sample_t push_data;
    tone_pkg::sample_t pop_data;

    phase_sequencer phase_sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .tone_step (tone_step),
        .ready     (ready),
        .sine      (sine),
        .full      (full),
        .update    (update),
        .angle     (angle),
        .push      (push),
        .push_data (push_data)
    );

    cordic_sine cordic_sine_i (
        .clk    (clk),
        .reset  (reset),
        .update (update),
        .angle  (angle),
        .ready  (ready),
        .sine   (sine)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sample_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    sample_serializer sample_serializer_i (
        .clk      (clk),
        .reset    (reset),
        .pop_data (pop_data),
        .empty    (empty),
        .dac_hold (dac_hold),
        .pop      (pop),
        .sdata    (sdata),
        .sframe   (sframe)
    );

endmodule

// ==== tone_gen_properties.sv ====
`timescale 1ns/1ps

module tone_gen_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    update,
    input logic                    ready,
    input logic                    push,
    input logic                    pop,
    input logic                    full,
    input logic                    empty,
    input logic                    sframe,
    input tone_pkg::cordic_state_t engine_state
);

    a_compute_quiet: assert property (@(posedge clk) disable iff (reset)
        engine_state == tone_pkg::CS_COMPUTE |-> !ready && !update)  // mid rotation
        else $error("ready or update high while the engine computes");

    a_push_ready: assert property (@(posedge clk) disable iff (reset)
        push |-> $rose(ready))              // first ready cycle of a fresh result
        else $error("push without a fresh ready");

    a_frame_single: assert property (@(posedge clk) disable iff (reset)
        sframe |=> !sframe)                 // one bit wide frame pulse
        else $error("sframe high in two cycles in a row");

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> !full)
        else $error("push into a full fifo");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty)
        else $error("pop from an empty fifo");

endmodule

bind tone_gen_top tone_gen_properties tone_gen_properties_i (
    .clk          (clk),
    .reset        (reset),
    .update       (update),
    .ready        (ready),
    .push         (push),
    .pop          (pop),
    .full         (full),
    .empty        (empty),
    .sframe       (sframe),
    .engine_state (cordic_sine_i.state)   // engine fsm seen from the top
);

// ==== tb_tone_gen.sv ====
`timescale 1ns/1ps

module tb_tone_gen;

    localparam int TOL       = 12;                          // cordic error budget, lsb
    localparam int PI2_INT   = int'(tone_pkg::PI2);
    localparam int FULL_TURN = 4 * PI2_INT;                 // 2*pi in angle units

    logic            clk;
    logic            reset;
    logic            enable;
    tone_pkg::step_t tone_step;
    logic            dac_hold;
    logic            sdata;
    logic            sframe;

    integer          seed;
    string           test_name;
    int              value_errors;
    int              timeout_errors;
    int              other_errors;
    bit              timed_out;                 // later waits are skipped
    bit              saw_full;
    bit   [3:0]      quad_seen;
    logic [15:0]     rx_word;
    int              rx_bits;                   // bits of the current word so far
    logic [15:0]     rx_q [$];                  // finished words for the compare
    int              rx_count;
    int              ref_phase;                 // phase of the next expected sample
    int              ref_step;
    int              got;
    int              exp_val;
    int              diff;

    tone_gen_top #(
        .FIFO_DEPTH (4)
    ) tone_gen_top_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .tone_step (tone_step),
        .dac_hold  (dac_hold),
        .sdata     (sdata),
        .sframe    (sframe)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                      // 40 ns period

    // same rule as the sequencer: add, then fold back once past 2*pi
    function automatic int next_phase(input int phase, input int step);
        int sum;
        sum = phase + step;
        if (sum >= FULL_TURN) begin
            sum = sum - FULL_TURN;
        end
        return sum;
    endfunction

    function automatic int ref_sine(input int phase);
        real rad;
        rad = real'(phase) / 16384.0;           // 14 fractional bits of radians
        return $rtoi(32767.0 * $sin(rad));
    endfunction

    // deserializer, msb first, word starts on sframe
    always @(negedge clk) begin
        if (reset) begin
            rx_bits = 0;                        // word cut by reset is dropped
        end else if (sframe) begin
            if (rx_bits != 0) begin
                $display("%s: frame pulse arrived in the middle of a sample", test_name);
                other_errors++;
            end
            rx_word = {15'd0, sdata};
            rx_bits = 1;
        end else if (rx_bits != 0) begin
            rx_word = {rx_word[14:0], sdata};
            rx_bits++;
        end
        if (rx_bits == 16) begin
            rx_q.push_back(rx_word);
            rx_bits = 0;
        end
    end

    // compare each received word with the reference sine
    always @(negedge clk) begin
        while (rx_q.size() > 0) begin
            got     = $signed(rx_q.pop_front());
            exp_val = ref_sine(ref_phase);
            diff    = got - exp_val;
            if (diff > TOL || diff < -TOL) begin
                $display("ERR %s sample %0d phase %0d expected %0d actual %0d",
                         test_name, rx_count, ref_phase, exp_val, got);
                value_errors++;
            end else begin
                quad_seen[ref_phase / PI2_INT] = 1'b1;  // quadrant covered by a good sample
            end
            ref_phase = next_phase(ref_phase, ref_step);
            rx_count++;
        end
    end

    always @(negedge clk) begin
        if (tone_gen_top_i.full) begin
            saw_full = 1'b1;                    // back pressure reached the sequencer
        end
    end

    task automatic wait_samples(input int n, input int limit);
        int target;
        int cycles;
        target = rx_count + n;
        cycles = 0;
        while (!timed_out && rx_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout in %s: %0d of %0d samples did not arrive",
                         test_name, target - rx_count, n);
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_quiet(input int limit);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (!timed_out && (quiet < 60 || rx_q.size() != 0)) begin
            @(negedge clk);
            cycles++;
            quiet = sframe ? 0 : quiet + 1;     // 60 idle cycles covers a sample in flight
            if (cycles > limit) begin
                $display("timeout in %s: serial output kept running after enable went low",
                         test_name);
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_frame(input int limit);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!timed_out && !seen) begin
            @(negedge clk);
            cycles++;
            seen = sframe;
            if (!seen && cycles > limit) begin
                $display("timeout in %s: no frame pulse appeared", test_name);
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_silent(input int n);
        repeat (n) begin
            @(negedge clk);
            if (sframe) begin
                $display("%s: sframe went high while the generator is stopped", test_name);
                other_errors++;
            end
        end
    endtask

    // stop, drain, then switch the step at a sample boundary
    task automatic change_step(input int step);
        enable = 1'b0;
        wait_quiet(1000);
        tone_step = tone_pkg::step_t'(step);
        ref_step  = step;                       // applies after the next sample
        enable    = 1'b1;
    endtask

    task automatic run_hold(input int n, input int limit);
        int target;
        int cycles;
        int burst;
        target = rx_count + n;
        cycles = 0;
        burst  = 0;
        while (!timed_out && rx_count < target) begin
            @(negedge clk);
            cycles++;
            if (burst == 0) begin
                dac_hold = !dac_hold;
                burst    = dac_hold ? 1 + ($random(seed) & 127) : 1 + ($random(seed) & 63);
            end
            burst--;
            if (cycles > limit) begin
                $display("timeout in %s: %0d of %0d samples did not arrive",
                         test_name, target - rx_count, n);
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
        dac_hold = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors: value %0d, timeout %0d, other %0d",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        seed           = 32'h2a47;
        reset          = 1'b1;
        enable         = 1'b0;
        tone_step      = '0;
        dac_hold       = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        timed_out      = 1'b0;
        saw_full       = 1'b0;
        quad_seen      = '0;
        ref_phase      = 0;
        ref_step       = 0;
        rx_count       = 0;
        test_name      = "reset";
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_name = "small_step";               // 40 samples span a bit over one turn
        tone_step = 18'd2900;
        ref_step  = 2900;
        enable    = 1'b1;
        wait_samples(40, 4000);
        if (quad_seen != 4'b1111) begin
            $display("small_step: not all four quadrants were reached");
            other_errors++;
        end

        test_name = "wrap";                     // step just below pi
        change_step(51000);
        wait_samples(30, 3000);

        test_name = "step_change";
        change_step(1234);
        wait_samples(30, 3000);

        test_name = "hold";
        saw_full  = 1'b0;
        run_hold(40, 20000);
        if (!saw_full) begin
            $display("hold: the fifo never filled under dac_hold");
            other_errors++;
        end

        test_name = "stop";
        enable    = 1'b0;
        wait_quiet(1000);
        check_silent(100);
        enable = 1'b1;
        wait_samples(5, 1000);                  // continues where it stopped

        test_name = "restart";
        wait_frame(1000);
        repeat (4) @(negedge clk);              // reset in the middle of a word
        reset = 1'b1;
        check_silent(8);
        ref_phase = 0;                          // sequencer restarts at phase 0
        reset     = 1'b0;
        wait_samples(10, 1000);

        finish_run();
    end

endmodule

// ==== vlog.f ====
tone_pkg.sv
phase_sequencer.sv
cordic_sine.sv
sample_fifo.sv
sample_serializer.sv
tone_gen_top.sv
tone_gen_properties.sv
tb_tone_gen.sv

// ==== run_sim.sh ====
#!/bin/bash
# build with verilator, run the testbench, then judge the run from its log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_tone_gen \
    -o tb_tone_gen > build.log 2>&1 \
    && ./obj_dir/tb_tone_gen > sim.log 2>&1 \
    || echo "build or simulation stopped with an error, see build.log and sim.log"

touch sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
